//--- verilog.f
logic/lsuPkg.sv
logic/loadStoreBuffer.sv
logic/dataCache.sv
logic/memCtrl.sv
logic/byteRam.sv
logic/lsuTop.sv
tb/lsuTb.sv

//--- tb/lsuTb.sv
`timescale 1ns/1ns

module lsuTb;
    import lsuPkg::*;

    localparam int bufDepth   = 4;
    localparam int numLines   = 16;
    localparam int ramDepth   = 4096;
    localparam int cycleLimit = 4000;  // About 200 operations at up to 12 cycles each.

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 issueValid;
    memOp                 issueOp;
    logic [addrWidth-1:0] issueAddr;
    logic [dataWidth-1:0] issueData;
    accessLen             issueLen;
    logic [nickWidth-1:0] issueNick;
    logic                 issueFull;
    logic                 resultValid;
    logic [dataWidth-1:0] resultData;
    logic [nickWidth-1:0] resultNick;

    logic [7:0]           model   [ramDepth];
    logic                 written [ramDepth];
    logic [nickWidth-1:0] expNick [$];
    logic [dataWidth-1:0] expData [$];
    logic [nickWidth-1:0] nextNick;
    int                   cycles = 0;
    integer               seed;

    lsuTop #(.bufDepth(bufDepth), .numLines(numLines), .ramDepth(ramDepth)) u_lsuTop (
        .clk, .rst, .rdy,
        .issueValid, .issueOp, .issueAddr, .issueData, .issueLen, .issueNick,
        .issueFull, .resultValid, .resultData, .resultNick
    );

    always #2 clk = ~clk;

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Value mismatch.");
        end
    endtask

    function automatic int byteCount(input accessLen len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    // Little-endian, zero-extended.
    function automatic logic [31:0] modelLoad(input logic [31:0] addr, input accessLen len);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < byteCount(len); i++) begin
            value[8*i +: 8] = model[(addr + i) % ramDepth];
        end
        return value;
    endfunction

    function automatic logic allWritten(input logic [31:0] addr, input accessLen len);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < byteCount(len); i++) begin
            ok = ok & written[(addr + i) % ramDepth];
        end
        return ok;
    endfunction

    task automatic sendOp(input memOp op, input logic [31:0] addr, input logic [31:0] data,
                          input accessLen len);
        while (issueFull || !rdy) begin
            @(posedge clk);
            #1;
        end
        issueValid = 1'b1;
        issueOp    = op;
        issueAddr  = addr;
        issueData  = data;
        issueLen   = len;
        issueNick  = nextNick;
        expNick.push_back(nextNick);
        if (op == opStore) begin
            expData.push_back('0);
            for (int i = 0; i < byteCount(len); i++) begin
                model[(addr + i) % ramDepth]   = data[8*i +: 8];
                written[(addr + i) % ramDepth] = 1'b1;
            end
        end else begin
            expData.push_back(modelLoad(addr, len));
        end
        nextNick = nextNick + 1'b1;
        @(posedge clk);
        #1;
        issueValid = 1'b0;
    endtask

    task automatic waitIdle();
        while (expNick.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Results are taken on edges where rdy is high.
    always @(posedge clk) begin
        logic [nickWidth-1:0] nick;
        logic [dataWidth-1:0] data;
        if (!rst && rdy && resultValid) begin
            if (expNick.size() == 0) begin
                $display("A result came back with no operation outstanding.");
                $display("Result: FAILED");
                $fatal(1, "Unexpected result.");
            end else begin
                nick = expNick.pop_front();
                data = expData.pop_front();
                checkEq(resultNick, nick, "result tag");
                checkEq(resultData, data, "result data");
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles.", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Timeout.");
        end
    end

    task automatic storeLoadLengths();
        sendOp(opStore, 32'h100, 32'hdead_beef, lenWord);
        sendOp(opStore, 32'h104, 32'hffff_1234, lenHalf);  // Upper bits must be ignored.
        sendOp(opStore, 32'h106, 32'h0000_abcd, lenHalf);
        sendOp(opStore, 32'h108, 32'h5555_5511, lenByte);
        sendOp(opStore, 32'h109, 32'h0000_0022, lenByte);
        sendOp(opStore, 32'h10a, 32'h0000_0033, lenByte);
        sendOp(opStore, 32'h10b, 32'h0000_0044, lenByte);
        sendOp(opLoad, 32'h100, '0, lenWord);
        sendOp(opLoad, 32'h104, '0, lenWord);
        sendOp(opLoad, 32'h108, '0, lenWord);
        sendOp(opLoad, 32'h102, '0, lenHalf);
        sendOp(opLoad, 32'h106, '0, lenHalf);
        sendOp(opLoad, 32'h10a, '0, lenHalf);
        sendOp(opLoad, 32'h103, '0, lenByte);
        sendOp(opLoad, 32'h105, '0, lenByte);
        sendOp(opLoad, 32'h10b, '0, lenByte);
        waitIdle();
    endtask

    task automatic hitTiming();
        sendOp(opStore, 32'h180, 32'hcafe_f00d, lenWord);
        sendOp(opLoad, 32'h180, '0, lenWord);
        waitIdle();
        sendOp(opLoad, 32'h180, '0, lenWord);  // Returns just after the issue edge.
        @(posedge clk);
        #1;
        checkEq(resultValid, 1'b0, "hit result one edge after issue");
        @(posedge clk);
        #1;
        checkEq(resultValid, 1'b1, "hit result two edges after issue");
        waitIdle();
    endtask

    task automatic writeThrough();
        sendOp(opStore, 32'h200, 32'h1122_3344, lenWord);
        sendOp(opStore, 32'h240, 32'h5566_7788, lenWord);  // Same line index.
        sendOp(opLoad, 32'h200, '0, lenWord);
        sendOp(opStore, 32'h201, 32'h0000_00a5, lenByte);
        sendOp(opLoad, 32'h200, '0, lenWord);
        sendOp(opLoad, 32'h240, '0, lenWord);
        sendOp(opLoad, 32'h200, '0, lenWord);
        waitIdle();
    endtask

    task automatic backPressure();
        logic sawFull;
        sawFull = 1'b0;
        for (int i = 0; i < 10; i++) begin
            sawFull = sawFull | issueFull;
            sendOp(i[0] ? opLoad : opStore, 32'h300 + 4 * (i / 2), 32'h0101_0101 * i, lenWord);
        end
        checkEq(sawFull, 1'b1, "issueFull under back-to-back issue");
        waitIdle();
    endtask

    task automatic rdyStall();
        logic                 heldValid;
        logic [nickWidth-1:0] heldNick;
        for (int i = 0; i < 6; i++) begin
            if (i == 3) begin
                rdy       = 1'b0;
                heldValid = resultValid;
                heldNick  = resultNick;
                repeat (10) begin
                    @(posedge clk);
                    #1;
                    checkEq(resultValid, heldValid, "resultValid during rdy stall");
                    checkEq(resultNick, heldNick, "resultNick during rdy stall");
                end
                rdy = 1'b1;
            end
            sendOp(i[0] ? opLoad : opStore, 32'h340 + 2 * (i / 2), 32'h0000_7a00 + i, lenHalf);
        end
        waitIdle();
    endtask

    task automatic randomMix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        memOp        op;
        accessLen    len;
        seed = 32'h4b6a_f948;
        for (int n = 0; n < 150; n++) begin
            r = $random(seed);
            case (r % 3)
                0:       len = lenByte;
                1:       len = lenHalf;
                default: len = lenWord;
            endcase
            addr = $random(seed);
            addr = addr & 32'h0000_00ff;
            addr = addr - (addr % byteCount(len));
            data = $random(seed);
            op   = r[8] ? opStore : opLoad;
            if (op == opLoad && !allWritten(addr, len)) begin
                op = opStore;
            end
            sendOp(op, addr, data, len);
        end
        waitIdle();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        issueValid = 1'b0;
        issueOp    = opLoad;
        issueAddr  = '0;
        issueData  = '0;
        issueLen   = lenWord;
        issueNick  = '0;
        nextNick   = '0;
        for (int i = 0; i < ramDepth; i++) begin
            written[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        storeLoadLengths();
        hitTiming();
        writeThrough();
        backPressure();
        rdyStall();
        randomMix();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- logic/lsuTop.sv
`timescale 1ns/1ns

module lsuTop #(
    parameter int bufDepth = 4,
    parameter int numLines = 16,
    parameter int ramDepth = 4096
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          issueValid,
    input  lsuPkg::memOp                  issueOp,
    input  logic [lsuPkg::addrWidth-1:0]  issueAddr,
    input  logic [lsuPkg::dataWidth-1:0]  issueData,
    input  lsuPkg::accessLen              issueLen,
    input  logic [lsuPkg::nickWidth-1:0]  issueNick,
    output logic                          issueFull,
    output logic                          resultValid,
    output logic [lsuPkg::dataWidth-1:0]  resultData,
    output logic [lsuPkg::nickWidth-1:0]  resultNick
);
    import lsuPkg::*;

    logic                        slbValid;
    memOp                        slbOp;
    logic [addrWidth-1:0]        slbAddr;
    logic [dataWidth-1:0]        slbData;
    accessLen                    slbLen;
    logic [nickWidth-1:0]        slbNick;
    logic                        cacheReady;

    logic                        mcReq;
    memOp                        mcOp;
    logic [addrWidth-1:0]        mcAddr;
    logic [dataWidth-1:0]        mcData;
    accessLen                    mcLen;
    logic                        mcBusy;
    logic                        mcDone;
    logic [dataWidth-1:0]        mcRdData;

    logic [$clog2(ramDepth)-1:0] ramAddr;
    logic                        ramWe;
    logic [7:0]                  ramWrData;
    logic [7:0]                  ramRdData;

    loadStoreBuffer #(.bufDepth(bufDepth)) u_loadStoreBuffer (
        .clk, .rst, .rdy,
        .issueValid, .issueOp, .issueAddr, .issueData, .issueLen, .issueNick,
        .cacheReady, .issueFull,
        .slbValid, .slbOp, .slbAddr, .slbData, .slbLen, .slbNick
    );

    dataCache #(.numLines(numLines)) u_dataCache (
        .clk, .rst, .rdy,
        .slbValid, .slbOp, .slbAddr, .slbData, .slbLen, .slbNick,
        .mcBusy, .mcDone, .mcRdData,
        .cacheReady, .mcReq, .mcOp, .mcAddr, .mcData, .mcLen,
        .resultValid, .resultData, .resultNick
    );

    memCtrl #(.ramDepth(ramDepth)) u_memCtrl (
        .clk, .rst, .rdy,
        .mcReq, .mcOp, .mcAddr, .mcData, .mcLen, .ramRdData,
        .mcBusy, .mcDone, .mcRdData,
        .ramAddr, .ramWe, .ramWrData
    );

    byteRam #(.ramDepth(ramDepth)) u_byteRam (
        .clk, .ramAddr, .ramWe, .ramWrData, .ramRdData
    );

endmodule

//--- logic/byteRam.sv
`timescale 1ns/1ns

module byteRam #(
    parameter int ramDepth = 4096
) (
    input  logic                        clk,
    input  logic [$clog2(ramDepth)-1:0] ramAddr,
    input  logic                        ramWe,
    input  logic [7:0]                  ramWrData,
    output logic [7:0]                  ramRdData
);

    logic [7:0] mem [ramDepth];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWrData;
        end
        ramRdData <= mem[ramAddr];  // Old data on a write.
    end

endmodule

//--- logic/memCtrl.sv
`timescale 1ns/1ns

module memCtrl #(
    parameter int ramDepth = 4096
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          mcReq,
    input  lsuPkg::memOp                  mcOp,
    input  logic [lsuPkg::addrWidth-1:0]  mcAddr,
    input  logic [lsuPkg::dataWidth-1:0]  mcData,
    input  lsuPkg::accessLen              mcLen,
    input  logic [7:0]                    ramRdData,
    output logic                          mcBusy,
    output logic                          mcDone,
    output logic [lsuPkg::dataWidth-1:0]  mcRdData,
    output logic [$clog2(ramDepth)-1:0]   ramAddr,
    output logic                          ramWe,
    output logic [7:0]                    ramWrData
);
    import lsuPkg::*;

    localparam int ramAw = $clog2(ramDepth);

    mcState               state;
    memOp                 opReg;
    logic [dataWidth-1:0] dataReg;
    logic [ramAw-1:0]     baseAddr;
    logic [ramAw-1:0]     curAddr;
    logic [ramAw-1:0]     prevAddr;  // Keeps the RAM output steady in a stall.
    logic                 weReg;
    logic [2:0]           numBytes;
    logic [2:0]           cnt;       // Bytes presented so far.
    logic [dataWidth-1:0] rdShift;

    assign mcBusy  = (state != mcIdle);
    assign mcDone  = (state == lsuPkg::mcDone);
    assign ramAddr = rdy ? curAddr : prevAddr;
    assign ramWe   = rdy & weReg;

    // Last byte is taken straight from the RAM in the done cycle.
    assign mcRdData = {ramRdData, rdShift[dataWidth-1:8]} >> {3'd4 - numBytes, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mcIdle;
            weReg <= 1'b0;
            cnt   <= '0;
        end else if (rdy) begin
            case (state)
                mcIdle: if (mcReq) begin
                    cnt   <= 3'd1;
                    weReg <= (mcOp == opStore);
                    state <= (mcOp == opStore && mcLen == lenByte) ? lsuPkg::mcDone : mcAccess;
                end
                mcAccess: begin
                    if (cnt != numBytes) begin
                        cnt <= cnt + 3'd1;
                    end
                    if (opReg == opStore && cnt == numBytes - 3'd1) begin
                        state <= lsuPkg::mcDone;
                    end else if (opReg == opLoad && cnt == numBytes) begin
                        state <= lsuPkg::mcDone;
                    end
                end
                default: begin
                    weReg <= 1'b0;
                    state <= mcIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            prevAddr <= curAddr;
            if (state == mcIdle && mcReq) begin
                opReg     <= mcOp;
                dataReg   <= mcData;
                numBytes  <= {1'b0, mcLen} + 3'd1;
                baseAddr  <= mcAddr[ramAw-1:0];
                curAddr   <= mcAddr[ramAw-1:0];
                ramWrData <= mcData[7:0];
            end else if (state == mcAccess && cnt != numBytes) begin
                curAddr   <= baseAddr + ramAw'(cnt);  // Wraps at ramDepth.
                ramWrData <= dataReg[8*cnt +: 8];
            end
            if (state == mcAccess && opReg == opLoad && cnt >= 3'd2) begin
                rdShift <= {ramRdData, rdShift[dataWidth-1:8]};
            end
        end
    end

endmodule

//--- logic/dataCache.sv
`timescale 1ns/1ns

module dataCache #(
    parameter int numLines = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          slbValid,
    input  lsuPkg::memOp                  slbOp,
    input  logic [lsuPkg::addrWidth-1:0]  slbAddr,
    input  logic [lsuPkg::dataWidth-1:0]  slbData,
    input  lsuPkg::accessLen              slbLen,
    input  logic [lsuPkg::nickWidth-1:0]  slbNick,
    input  logic                          mcBusy,
    input  logic                          mcDone,
    input  logic [lsuPkg::dataWidth-1:0]  mcRdData,
    output logic                          cacheReady,
    output logic                          mcReq,
    output lsuPkg::memOp                  mcOp,
    output logic [lsuPkg::addrWidth-1:0]  mcAddr,
    output logic [lsuPkg::dataWidth-1:0]  mcData,
    output lsuPkg::accessLen              mcLen,
    output logic                          resultValid,
    output logic [lsuPkg::dataWidth-1:0]  resultData,
    output logic [lsuPkg::nickWidth-1:0]  resultNick
);
    import lsuPkg::*;

    localparam int idxW = $clog2(numLines);
    localparam int tagW = addrWidth - idxW - 2;

    logic                 occupied;
    logic                 reqSent;  // Waiting on the memory controller.
    memOp                 opReg;
    logic [addrWidth-1:0] addrReg;
    logic [dataWidth-1:0] dataReg;
    accessLen             lenReg;
    logic [nickWidth-1:0] nickReg;

    logic [dataWidth-1:0] lineData [numLines];
    logic [tagW-1:0]      lineTag  [numLines];
    logic [numLines-1:0]  lineValid;

    logic [idxW-1:0]      idx;
    logic [tagW-1:0]      tag;
    logic [4:0]           shAmt;
    logic                 hit;
    logic [dataWidth-1:0] lenMask;
    logic [dataWidth-1:0] laneMask;
    logic [dataWidth-1:0] curWord;
    logic [dataWidth-1:0] loadValue;
    logic [dataWidth-1:0] storeWord;

    assign idx        = addrReg[2 +: idxW];
    assign tag        = addrReg[addrWidth-1 -: tagW];
    assign shAmt      = {addrReg[1:0], 3'b000};
    assign hit        = lineValid[idx] && (lineTag[idx] == tag);
    assign cacheReady = ~occupied;

    always_comb begin
        case (lenReg)
            lenByte: lenMask = 32'h0000_00ff;
            lenHalf: lenMask = 32'h0000_ffff;
            default: lenMask = '1;
        endcase
    end

    // Fill data replaces the line while a miss completes.
    assign curWord   = reqSent ? mcRdData : lineData[idx];
    assign loadValue = (curWord >> shAmt) & lenMask;  // Zero-extended.
    assign laneMask  = lenMask << shAmt;
    assign storeWord = (lineData[idx] & ~laneMask) | ((dataReg << shAmt) & laneMask);

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied    <= 1'b0;
            reqSent     <= 1'b0;
            mcReq       <= 1'b0;
            resultValid <= 1'b0;
            lineValid   <= '0;
        end else if (rdy) begin
            mcReq       <= 1'b0;
            resultValid <= 1'b0;
            if (!occupied) begin
                if (slbValid) begin
                    occupied <= 1'b1;
                end
            end else if (!reqSent) begin
                if (opReg == opLoad && hit) begin
                    resultValid <= 1'b1;
                    occupied    <= 1'b0;
                end else if (!mcBusy) begin
                    mcReq   <= 1'b1;  // Miss or write-through.
                    reqSent <= 1'b1;
                end
            end else if (mcDone) begin
                resultValid <= 1'b1;
                occupied    <= 1'b0;
                reqSent     <= 1'b0;
                if (opReg == opLoad) begin
                    lineValid[idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (!occupied && slbValid) begin
                opReg   <= slbOp;
                addrReg <= slbAddr;
                dataReg <= slbData;
                lenReg  <= slbLen;
                nickReg <= slbNick;
            end
            if (occupied && !reqSent) begin
                mcOp   <= opReg;
                mcData <= dataReg;
                if (opReg == opStore) begin
                    mcAddr <= addrReg;
                    mcLen  <= lenReg;
                end else begin
                    mcAddr <= {addrReg[addrWidth-1:2], 2'b00};  // Whole line.
                    mcLen  <= lenWord;
                end
                if (opReg == opLoad && hit) begin
                    resultData <= loadValue;
                    resultNick <= nickReg;
                end
            end
            if (occupied && reqSent && mcDone) begin
                resultNick <= nickReg;
                resultData <= (opReg == opLoad) ? loadValue : '0;
                if (opReg == opLoad) begin
                    lineData[idx] <= mcRdData;
                    lineTag[idx]  <= tag;
                end else if (hit) begin
                    lineData[idx] <= storeWord;
                end
            end
        end
    end

endmodule

//--- logic/loadStoreBuffer.sv
`timescale 1ns/1ns

module loadStoreBuffer #(
    parameter int bufDepth = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          issueValid,
    input  lsuPkg::memOp                  issueOp,
    input  logic [lsuPkg::addrWidth-1:0]  issueAddr,
    input  logic [lsuPkg::dataWidth-1:0]  issueData,
    input  lsuPkg::accessLen              issueLen,
    input  logic [lsuPkg::nickWidth-1:0]  issueNick,
    input  logic                          cacheReady,
    output logic                          issueFull,
    output logic                          slbValid,
    output lsuPkg::memOp                  slbOp,
    output logic [lsuPkg::addrWidth-1:0]  slbAddr,
    output logic [lsuPkg::dataWidth-1:0]  slbData,
    output lsuPkg::accessLen              slbLen,
    output logic [lsuPkg::nickWidth-1:0]  slbNick
);
    import lsuPkg::*;

    localparam int ptrW = (bufDepth > 1) ? $clog2(bufDepth) : 1;
    localparam int cntW = $clog2(bufDepth + 1);

    memOp                 opMem   [bufDepth];
    logic [addrWidth-1:0] addrMem [bufDepth];
    logic [dataWidth-1:0] dataMem [bufDepth];
    accessLen             lenMem  [bufDepth];
    logic [nickWidth-1:0] nickMem [bufDepth];

    logic [ptrW-1:0] head;
    logic [ptrW-1:0] tail;
    logic [cntW-1:0] count;
    logic            push;
    logic            pop;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(bufDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign issueFull = (count == cntW'(bufDepth));
    assign slbValid  = (count != '0);
    assign push      = issueValid && !issueFull;
    assign pop       = slbValid && cacheReady;  // Taken by the cache.

    // Oldest entry goes out first.
    assign slbOp   = opMem[head];
    assign slbAddr = addrMem[head];
    assign slbData = dataMem[head];
    assign slbLen  = lenMem[head];
    assign slbNick = nickMem[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                tail <= nextPtr(tail);
            end
            if (pop) begin
                head <= nextPtr(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && push) begin
            opMem[tail]   <= issueOp;
            addrMem[tail] <= issueAddr;
            dataMem[tail] <= issueData;
            lenMem[tail]  <= issueLen;
            nickMem[tail] <= issueNick;
        end
    end

endmodule

//--- logic/lsuPkg.sv
package lsuPkg;

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int nickWidth = 4;  // Reorder-buffer index.
    localparam int lenWidth  = 2;

    typedef enum logic {
        opLoad,
        opStore
    } memOp;

    // Code plus one gives the byte count.
    typedef enum logic [lenWidth-1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd3
    } accessLen;

    typedef enum logic [1:0] {
        mcIdle,
        mcAccess,
        mcDone
    } mcState;

endpackage
